/* sim.f */
+incdir+verif
verilog/burst_split_pkg.sv
verilog/ar_decode.sv
verilog/beat_issue.sv
verilog/burst_track_fifo.sv
verilog/r_result.sv
verilog/burst_split_top.sv
verif/tb_burst_split.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the burst splitter simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_burst_split \
  -Mdir obj_dir -o tb_burst_split
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_burst_split > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* verif/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  // Expected downstream single-beat ARs in issue order
  logic [IdWidth-1:0] exp_ar_id[$];
  logic [31:0]        exp_ar_addr[$];
  logic [2:0]         exp_ar_size[$];
  logic [1:0]         exp_ar_burst[$];

  // Expected upstream R beats in burst arrival order
  logic [IdWidth-1:0] exp_r_id[$];
  logic [31:0]        exp_r_data[$];
  logic [1:0]         exp_r_resp[$];
  logic               exp_r_last[$];

  // Memory contents returned by the downstream responder
  function automatic logic [31:0] mem_data(input logic [31:0] addr);
    return addr ^ 32'h5a5a0000;
  endfunction

  // AXI burst codes are FIXED 00, INCR 01, WRAP 10
  function automatic bit burst_supported(input logic [7:0] len, input logic [1:0] burst,
                                         input logic [3:0] cache);
    bit wrap_multi;
    bit long_incr;
    wrap_multi = (burst == 2'b10);
    long_incr  = (burst == 2'b01) && (len > 8'd16);
    // Unsupported means multi-beat and either WRAP or non-modifiable short/non-INCR
    return !((len != 8'd0) && (wrap_multi || (!cache[1] && !long_incr)));
  endfunction

  // Address of beat k of a burst
  function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [2:0] size,
                                            input logic [1:0] burst, input int unsigned k);
    if (burst == 2'b01) begin
      return start + k * (32'd1 << size);
    end
    return start;
  endfunction

  task automatic record_burst(input logic [IdWidth-1:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst, input logic [3:0] cache);
    bit          ok;
    int unsigned k;
    ok = burst_supported(len, burst, cache);
    for (k = 0; k <= len; k++) begin
      if (ok) begin
        exp_ar_id.push_back(id);
        exp_ar_addr.push_back(beat_addr(addr, size, burst, k));
        exp_ar_size.push_back(size);
        exp_ar_burst.push_back(burst);
      end
      exp_r_id.push_back(id);
      exp_r_data.push_back(ok ? mem_data(beat_addr(addr, size, burst, k)) : 32'd0);
      exp_r_resp.push_back(ok ? 2'b00 : 2'b10);
      exp_r_last.push_back(k == len);
    end
  endtask

`endif

/* verif/tb_burst_split.sv */
`timescale 1ns/1ps

module tb_burst_split;

  localparam int unsigned IdWidth       = 4;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned NumBursts     = 200;
  // Up to 21 beats per burst at 8 cycles per beat
  localparam int unsigned TimeoutCycles = NumBursts * 21 * 8;

  logic                 clk_i;
  logic                 rst_i;
  logic                 s_ar_valid_i;
  logic [IdWidth-1:0]   s_ar_id_i;
  logic [31:0]          s_ar_addr_i;
  logic [7:0]           s_ar_len_i;
  logic [2:0]           s_ar_size_i;
  logic [1:0]           s_ar_burst_i;
  logic [3:0]           s_ar_cache_i;
  logic                 s_ar_ready_o;
  logic                 m_ar_valid_o;
  logic [IdWidth-1:0]   m_ar_id_o;
  logic [31:0]          m_ar_addr_o;
  logic [7:0]           m_ar_len_o;
  logic [2:0]           m_ar_size_o;
  logic [1:0]           m_ar_burst_o;
  logic                 m_ar_ready_i;
  logic                 m_r_valid_i;
  logic [IdWidth-1:0]   m_r_id_i;
  logic [DataWidth-1:0] m_r_data_i;
  logic [1:0]           m_r_resp_i;
  logic                 m_r_ready_o;
  logic                 s_r_valid_o;
  logic [IdWidth-1:0]   s_r_id_o;
  logic [DataWidth-1:0] s_r_data_o;
  logic [1:0]           s_r_resp_o;
  logic                 s_r_last_o;
  logic                 s_r_ready_i;

  // Downstream responder state
  logic [IdWidth-1:0]   rsp_id[$];
  logic [31:0]          rsp_addr[$];
  logic                 r_pending;
  int unsigned          cycle_count;
  int unsigned          error_count;

  `include "tb_ref_model.svh"

  burst_split_top #(
    .IdWidth     (IdWidth),
    .DataWidth   (DataWidth),
    .MaxReadTxns (4)
  ) i_burst_split_top (.*);

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else
      abort_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Upstream AR stimulus
  // --------------------------------------------------
  initial begin
    int unsigned n;
    void'($urandom(32'h9fe6));
    rst_i        = 1'b1;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = '0;
    s_ar_cache_i = '0;
    m_ar_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    s_r_ready_i  = 1'b0;
    r_pending    = 1'b0;
    cycle_count  = 0;
    error_count  = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    // Idle state right after reset
    check_value("s_r_valid_o", 32'(s_r_valid_o), 32'd0);
    check_value("m_ar_valid_o", 32'(m_ar_valid_o), 32'd0);
    check_value("m_r_ready_o", 32'(m_r_ready_o), 32'd0);
    check_value("s_ar_ready_o", 32'(s_ar_ready_o), 32'd1);
    for (n = 0; n < NumBursts; n++) begin
      s_ar_valid_i = 1'b1;
      s_ar_id_i    = IdWidth'($urandom_range(0, 15));
      s_ar_len_i   = 8'($urandom_range(0, 20));
      s_ar_size_i  = 3'($urandom_range(0, 2));
      s_ar_burst_i = 2'($urandom_range(0, 2));
      s_ar_cache_i = 4'($urandom);
      s_ar_addr_i  = $urandom & ~((32'd1 << s_ar_size_i) - 32'd1);
      do @(posedge clk_i); while (!s_ar_ready_o);
      @(negedge clk_i);
      s_ar_valid_i = 1'b0;
      repeat ($urandom_range(0, 2)) @(negedge clk_i);
    end
    while ((exp_r_id.size() != 0) || (exp_ar_addr.size() != 0)) @(posedge clk_i);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // --------------------------------------------------
  // Downstream responder and upstream ready
  // --------------------------------------------------
  always @(negedge clk_i) begin
    m_ar_ready_i = ($urandom_range(0, 3) != 0);
    s_r_ready_i  = ($urandom_range(0, 3) != 0);
    // Beat is held until the DUT takes it
    if (!r_pending) begin
      m_r_valid_i = 1'b0;
      if ((rsp_addr.size() != 0) && ($urandom_range(0, 2) != 0)) begin
        m_r_valid_i = 1'b1;
        m_r_id_i    = rsp_id.pop_front();
        m_r_data_i  = mem_data(rsp_addr.pop_front());
        m_r_resp_i  = 2'b00;
        r_pending   = 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Monitors
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (s_ar_valid_i && s_ar_ready_o) begin
        record_burst(s_ar_id_i, s_ar_addr_i, s_ar_len_i, s_ar_size_i, s_ar_burst_i,
                     s_ar_cache_i);
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        assert (exp_ar_addr.size() != 0) else
          abort_run("Downstream AR issued while no supported beat was expected");
        check_value("m_ar_len_o", 32'(m_ar_len_o), 32'd0);
        check_value("m_ar_id_o", 32'(m_ar_id_o), 32'(exp_ar_id.pop_front()));
        check_value("m_ar_addr_o", m_ar_addr_o, exp_ar_addr.pop_front());
        check_value("m_ar_size_o", 32'(m_ar_size_o), 32'(exp_ar_size.pop_front()));
        check_value("m_ar_burst_o", 32'(m_ar_burst_o), 32'(exp_ar_burst.pop_front()));
        rsp_id.push_back(m_ar_id_o);
        rsp_addr.push_back(m_ar_addr_o);
      end
      if (m_r_valid_i && m_r_ready_o) begin
        r_pending = 1'b0;
      end
      if (s_r_valid_o && s_r_ready_i) begin
        assert (exp_r_id.size() != 0) else
          abort_run("Upstream R beat arrived while none was expected");
        check_value("s_r_id_o", 32'(s_r_id_o), 32'(exp_r_id.pop_front()));
        check_value("s_r_data_o", s_r_data_o, exp_r_data.pop_front());
        check_value("s_r_resp_o", 32'(s_r_resp_o), 32'(exp_r_resp.pop_front()));
        check_value("s_r_last_o", 32'(s_r_last_o), 32'(exp_r_last.pop_front()));
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      abort_run("Timeout before all expected upstream R beats were seen");
    end
  end

endmodule

/* verilog/burst_split_top.sv */
`timescale 1ns/1ps

module burst_split_top #(
  parameter int unsigned IdWidth     = 4,
  parameter int unsigned DataWidth   = 32,
  parameter int unsigned MaxReadTxns = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Upstream AR
  input  logic                                   s_ar_valid_i,
  input  logic [IdWidth-1:0]                     s_ar_id_i,
  input  logic [burst_split_pkg::AddrWidth-1:0]  s_ar_addr_i,
  input  logic [burst_split_pkg::LenWidth-1:0]   s_ar_len_i,
  input  logic [burst_split_pkg::SizeWidth-1:0]  s_ar_size_i,
  input  logic [1:0]                             s_ar_burst_i,
  input  logic [burst_split_pkg::CacheWidth-1:0] s_ar_cache_i,
  output logic                                   s_ar_ready_o,
  // Downstream AR
  output logic                                   m_ar_valid_o,
  output logic [IdWidth-1:0]                     m_ar_id_o,
  output logic [burst_split_pkg::AddrWidth-1:0]  m_ar_addr_o,
  output logic [burst_split_pkg::LenWidth-1:0]   m_ar_len_o,
  output logic [burst_split_pkg::SizeWidth-1:0]  m_ar_size_o,
  output logic [1:0]                             m_ar_burst_o,
  input  logic                                   m_ar_ready_i,
  // Downstream R
  input  logic                                   m_r_valid_i,
  input  logic [IdWidth-1:0]                     m_r_id_i,
  input  logic [DataWidth-1:0]                   m_r_data_i,
  input  logic [1:0]                             m_r_resp_i,
  output logic                                   m_r_ready_o,
  // Upstream R
  output logic                                   s_r_valid_o,
  output logic [IdWidth-1:0]                     s_r_id_o,
  output logic [DataWidth-1:0]                   s_r_data_o,
  output logic [1:0]                             s_r_resp_o,
  output logic                                   s_r_last_o,
  input  logic                                   s_r_ready_i
);

  logic                                 load;
  logic                                 issue_busy;
  logic                                 push;
  logic                                 push_err;
  logic                                 fifo_full;
  logic                                 head_valid;
  logic [burst_split_pkg::LenWidth-1:0] head_len;
  logic [IdWidth-1:0]                   head_id;
  logic                                 head_err;
  logic                                 pop;

  ar_decode i_ar_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_burst_i (s_ar_burst_i),
    .s_ar_cache_i (s_ar_cache_i),
    .issue_busy_i (issue_busy),
    .fifo_full_i  (fifo_full),
    .s_ar_ready_o (s_ar_ready_o),
    .load_o       (load),
    .push_o       (push),
    .push_err_o   (push_err)
  );

  beat_issue #(
    .IdWidth (IdWidth)
  ) i_beat_issue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .load_i       (load),
    .ar_id_i      (s_ar_id_i),
    .ar_addr_i    (s_ar_addr_i),
    .ar_len_i     (s_ar_len_i),
    .ar_size_i    (s_ar_size_i),
    .ar_burst_i   (s_ar_burst_i),
    .m_ar_ready_i (m_ar_ready_i),
    .busy_o       (issue_busy),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o)
  );

  burst_track_fifo #(
    .IdWidth     (IdWidth),
    .MaxReadTxns (MaxReadTxns)
  ) i_burst_track_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (push),
    .push_len_i  (s_ar_len_i),
    .push_id_i   (s_ar_id_i),
    .push_err_i  (push_err),
    .pop_i       (pop),
    .full_o      (fifo_full),
    .not_empty_o (head_valid),
    .head_len_o  (head_len),
    .head_id_o   (head_id),
    .head_err_o  (head_err)
  );

  r_result #(
    .IdWidth   (IdWidth),
    .DataWidth (DataWidth)
  ) i_r_result (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_valid_i (head_valid),
    .head_len_i   (head_len),
    .head_id_i    (head_id),
    .head_err_i   (head_err),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_id_i     (m_r_id_i),
    .m_r_data_i   (m_r_data_i),
    .m_r_resp_i   (m_r_resp_i),
    .s_r_ready_i  (s_r_ready_i),
    .pop_o        (pop),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_id_o     (s_r_id_o),
    .s_r_data_o   (s_r_data_o),
    .s_r_resp_o   (s_r_resp_o),
    .s_r_last_o   (s_r_last_o)
  );

endmodule

/* verilog/r_result.sv */
`timescale 1ns/1ps

module r_result #(
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned DataWidth = 32
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Head of the tracking queue
  input  logic                                 head_valid_i,
  input  logic [burst_split_pkg::LenWidth-1:0] head_len_i,
  input  logic [IdWidth-1:0]                   head_id_i,
  input  logic                                 head_err_i,
  // Downstream R
  input  logic                                 m_r_valid_i,
  input  logic [IdWidth-1:0]                   m_r_id_i,
  input  logic [DataWidth-1:0]                 m_r_data_i,
  input  logic [1:0]                           m_r_resp_i,
  // Upstream R ready
  input  logic                                 s_r_ready_i,
  output logic                                 pop_o,
  output logic                                 m_r_ready_o,
  output logic                                 s_r_valid_o,
  output logic [IdWidth-1:0]                   s_r_id_o,
  output logic [DataWidth-1:0]                 s_r_data_o,
  output logic [1:0]                           s_r_resp_o,
  output logic                                 s_r_last_o
);

  logic [burst_split_pkg::LenWidth-1:0] beat_cnt_q;
  logic                                 pass_mode;
  logic                                 err_mode;
  logic                                 up_hs;

  assign pass_mode = head_valid_i && !head_err_i;
  assign err_mode  = head_valid_i && head_err_i;

  // --------------------------------------------------
  // Beat select
  // --------------------------------------------------
  always_comb begin
    s_r_valid_o = 1'b0;
    m_r_ready_o = 1'b0;
    s_r_id_o    = m_r_id_i;
    s_r_data_o  = m_r_data_i;
    s_r_resp_o  = m_r_resp_i;
    if (pass_mode) begin
      // Feed through, only last is rebuilt
      s_r_valid_o = m_r_valid_i;
      m_r_ready_o = s_r_ready_i;
    end else if (err_mode) begin
      // Local SLVERR beats, downstream stays stalled
      s_r_valid_o = 1'b1;
      s_r_id_o    = head_id_i;
      s_r_data_o  = '0;
      s_r_resp_o  = burst_split_pkg::RESP_SLVERR;
    end
  end

  // Remaining beats of the head reach zero when the count meets len
  assign s_r_last_o = (beat_cnt_q == head_len_i);
  assign up_hs      = s_r_valid_o && s_r_ready_i;
  assign pop_o      = up_hs && s_r_last_o;

  // --------------------------------------------------
  // Beat counter
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt_q <= '0;
    end else if (pop_o) begin
      beat_cnt_q <= '0;
    end else if (up_hs) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // Downstream may only answer ARs that were tracked
  assert property (@(posedge clk_i) disable iff (rst_i) m_r_valid_i |-> head_valid_i)
    else $error("Downstream R beat with no tracked burst");

endmodule

/* verilog/burst_track_fifo.sv */
`timescale 1ns/1ps

module burst_track_fifo #(
  parameter int unsigned IdWidth     = 4,
  parameter int unsigned MaxReadTxns = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 push_i,
  input  logic [burst_split_pkg::LenWidth-1:0] push_len_i,
  input  logic [IdWidth-1:0]                   push_id_i,
  input  logic                                 push_err_i,
  input  logic                                 pop_i,
  output logic                                 full_o,
  output logic                                 not_empty_o,
  output logic [burst_split_pkg::LenWidth-1:0] head_len_o,
  output logic [IdWidth-1:0]                   head_id_o,
  output logic                                 head_err_o
);

  localparam int unsigned PtrWidth = (MaxReadTxns > 1) ? $clog2(MaxReadTxns) : 1;
  localparam int unsigned CntWidth = $clog2(MaxReadTxns + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(MaxReadTxns - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(MaxReadTxns);

  logic [burst_split_pkg::LenWidth-1:0] len_mem [MaxReadTxns];
  logic [IdWidth-1:0]                   id_mem  [MaxReadTxns];
  logic                                 err_mem [MaxReadTxns];
  logic [PtrWidth-1:0]                  wr_ptr_q;
  logic [PtrWidth-1:0]                  rd_ptr_q;
  logic [CntWidth-1:0]                  count_q;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      len_mem[wr_ptr_q] <= push_len_i;
      id_mem[wr_ptr_q]  <= push_id_i;
      err_mem[wr_ptr_q] <= push_err_i;
    end
  end

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign full_o      = (count_q == FullCnt);
  assign not_empty_o = (count_q != '0);
  assign head_len_o  = len_mem[rd_ptr_q];
  assign head_id_o   = id_mem[rd_ptr_q];
  assign head_err_o  = err_mem[rd_ptr_q];

  assert property (@(posedge clk_i) disable iff (rst_i)
    !(push_i && full_o) && !(pop_i && !not_empty_o))
    else $error("Tracking queue overflow or underflow");

endmodule

/* verilog/beat_issue.sv */
`timescale 1ns/1ps

module beat_issue #(
  parameter int unsigned IdWidth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  load_i,
  input  logic [IdWidth-1:0]                    ar_id_i,
  input  logic [burst_split_pkg::AddrWidth-1:0] ar_addr_i,
  input  logic [burst_split_pkg::LenWidth-1:0]  ar_len_i,
  input  logic [burst_split_pkg::SizeWidth-1:0] ar_size_i,
  input  logic [1:0]                            ar_burst_i,
  input  logic                                  m_ar_ready_i,
  output logic                                  busy_o,
  output logic                                  m_ar_valid_o,
  output logic [IdWidth-1:0]                    m_ar_id_o,
  output logic [burst_split_pkg::AddrWidth-1:0] m_ar_addr_o,
  output logic [burst_split_pkg::LenWidth-1:0]  m_ar_len_o,
  output logic [burst_split_pkg::SizeWidth-1:0] m_ar_size_o,
  output logic [1:0]                            m_ar_burst_o
);

  burst_split_pkg::issue_state_e         state_q;
  logic [IdWidth-1:0]                    id_q;
  logic [burst_split_pkg::AddrWidth-1:0] addr_q;
  logic [burst_split_pkg::AddrWidth-1:0] addr_step;
  logic [burst_split_pkg::LenWidth-1:0]  remain_q;
  logic [burst_split_pkg::SizeWidth-1:0] size_q;
  logic [1:0]                            burst_q;
  logic                                  beat_hs;
  logic                                  last_beat;

  assign beat_hs   = m_ar_valid_o && m_ar_ready_i;
  assign last_beat = (remain_q == '0);

  // Address increment of one beat is zero for FIXED
  always_comb begin
    addr_step = '0;
    if (burst_q == burst_split_pkg::BURST_INCR) begin
      addr_step[size_q] = 1'b1;
    end
  end

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= burst_split_pkg::ISSUE_IDLE;
    end else begin
      case (state_q)
        burst_split_pkg::ISSUE_IDLE: begin
          if (load_i) begin
            state_q <= burst_split_pkg::ISSUE_BUSY;
          end
        end
        burst_split_pkg::ISSUE_BUSY: begin
          if (beat_hs && last_beat) begin
            state_q <= burst_split_pkg::ISSUE_IDLE;
          end
        end
        default: state_q <= burst_split_pkg::ISSUE_IDLE;
      endcase
    end
  end

  // Burst registers advance once per accepted beat
  always_ff @(posedge clk_i) begin
    if (load_i && (state_q == burst_split_pkg::ISSUE_IDLE)) begin
      id_q     <= ar_id_i;
      addr_q   <= ar_addr_i;
      remain_q <= ar_len_i;
      size_q   <= ar_size_i;
      burst_q  <= ar_burst_i;
    end else if (beat_hs && !last_beat) begin
      remain_q <= remain_q - 1'b1;
      addr_q   <= addr_q + addr_step;
    end
  end

  // --------------------------------------------------
  // Downstream AR
  // --------------------------------------------------
  assign busy_o       = (state_q == burst_split_pkg::ISSUE_BUSY);
  assign m_ar_valid_o = busy_o;
  assign m_ar_id_o    = id_q;
  assign m_ar_addr_o  = addr_q;
  assign m_ar_len_o   = '0;
  assign m_ar_size_o  = size_q;
  assign m_ar_burst_o = burst_q;

  assert property (@(posedge clk_i) disable iff (rst_i) m_ar_valid_o |-> (m_ar_len_o == '0))
    else $error("Downstream AR with len other than zero");

endmodule

/* verilog/ar_decode.sv */
`timescale 1ns/1ps

module ar_decode (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   s_ar_valid_i,
  input  logic [burst_split_pkg::LenWidth-1:0]   s_ar_len_i,
  input  logic [1:0]                             s_ar_burst_i,
  input  logic [burst_split_pkg::CacheWidth-1:0] s_ar_cache_i,
  input  logic                                   issue_busy_i,
  input  logic                                   fifo_full_i,
  output logic                                   s_ar_ready_o,
  output logic                                   load_o,
  output logic                                   push_o,
  output logic                                   push_err_o
);

  logic supported;
  logic modifiable;
  logic is_wrap;
  logic is_incr;

  // --------------------------------------------------
  // Support rule
  // --------------------------------------------------
  assign modifiable = s_ar_cache_i[burst_split_pkg::CacheModBit];
  assign is_wrap    = (s_ar_burst_i == burst_split_pkg::BURST_WRAP);
  assign is_incr    = (s_ar_burst_i == burst_split_pkg::BURST_INCR);

  always_comb begin
    if (s_ar_len_i == '0) begin
      // Single beats pass through as they are
      supported = 1'b1;
    end else if (is_wrap) begin
      supported = 1'b0;
    end else if (!modifiable) begin
      // Splitting a non-modifiable burst is only legal for long INCR
      supported = is_incr && (s_ar_len_i > burst_split_pkg::MaxSplitLen);
    end else begin
      supported = 1'b1;
    end
  end

  // --------------------------------------------------
  // Handshake and strobes
  // --------------------------------------------------
  // Unsupported bursts only need a queue slot, supported ones also the issuer
  assign s_ar_ready_o = !fifo_full_i && (!supported || !issue_busy_i);
  assign push_o       = s_ar_valid_i && s_ar_ready_o;
  assign load_o       = push_o && supported;
  assign push_err_o   = !supported;

  // Queue must never see a push it cannot store
  assert property (@(posedge clk_i) disable iff (rst_i) !(push_o && fifo_full_i))
    else $error("AR pushed into full tracking queue");

endmodule

/* verilog/burst_split_pkg.sv */
package burst_split_pkg;

  // --------------------------------------------------
  // AR channel field widths
  // --------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned LenWidth   = 8;
  localparam int unsigned SizeWidth  = 3;
  localparam int unsigned CacheWidth = 4;

  // Non-modifiable INCR bursts longer than this may be split
  localparam logic [LenWidth-1:0] MaxSplitLen = 8'd16;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  // Burst type, AXI encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Response codes used on R
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Beat issuer FSM
  typedef enum logic {
    ISSUE_IDLE = 1'b0,
    ISSUE_BUSY = 1'b1
  } issue_state_e;

  // Cache bit 1 marks a modifiable transaction
  localparam int unsigned CacheModBit = 1;

endpackage
